//--- logic/stream_pkg.sv
package stream_pkg;

    // sample width, the struct types below are built on it
    localparam int SAMPLE_W = 16;

    localparam int AXIL_ADDR_W = 4;
    localparam int AXIL_DATA_W = 32;
    localparam logic [1:0] AXIL_RESP_OKAY = 2'b00;

    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // unsigned Q8.8, 256 is unity
    typedef logic [15:0] gain_t;

    // a length of 0 is handled as 1
    typedef logic [15:0] frame_len_t;

    typedef struct packed {
        sample_t sample;
        logic    last;
    } sample_beat_t;

    // master-driven AXI4-Lite signals
    typedef struct packed {
        logic [AXIL_ADDR_W-1:0]   awaddr;
        logic                     awvalid;
        logic [AXIL_DATA_W-1:0]   wdata;
        logic [AXIL_DATA_W/8-1:0] wstrb;
        logic                     wvalid;
        logic                     bready;
        logic [AXIL_ADDR_W-1:0]   araddr;
        logic                     arvalid;
        logic                     rready;
    } axil_req_t;

    // slave-driven AXI4-Lite signals
    typedef struct packed {
        logic                   awready;
        logic                   wready;
        logic [1:0]             bresp;
        logic                   bvalid;
        logic                   arready;
        logic [AXIL_DATA_W-1:0] rdata;
        logic [1:0]             rresp;
        logic                   rvalid;
    } axil_rsp_t;

    typedef struct packed {
        logic [15:0] level;
        logic        full;
        logic        empty;
        logic        overflow;
    } fifo_status_t;

    typedef enum logic [AXIL_ADDR_W-1:0] {
        REG_GAIN      = 4'h0,
        REG_FRAME_LEN = 4'h4,
        REG_STATUS    = 4'h8
    } csr_addr_e;

endpackage

//--- logic/sample_scaler.sv
`timescale 1ns/1ps

module sample_scaler
    import stream_pkg::*;
(
    input  logic         clk_i,
    input  logic         reset_ni,
    input  logic         in_valid_i,
    input  sample_t      in_sample_i,
    input  gain_t        gain_i,
    output logic         out_valid_o,
    output sample_beat_t out_beat_o
);

    // signed sample times a 17-bit positive gain
    localparam int PROD_W  = SAMPLE_W + 17;
    localparam int SHIFT_W = PROD_W - 8;

    localparam logic signed [SHIFT_W-1:0] SAT_MAX = SHIFT_W'((1 << (SAMPLE_W - 1)) - 1);
    localparam logic signed [SHIFT_W-1:0] SAT_MIN = -SAT_MAX - 1;

    logic signed [PROD_W-1:0]  product;
    logic signed [PROD_W-1:0]  rounded;
    logic signed [SHIFT_W-1:0] shifted;
    sample_t                   clamped;

    // a zero msb keeps the gain positive inside the signed multiply
    assign product = in_sample_i * $signed({1'b0, gain_i});

    // half an lsb of Q8.8 before dropping the fraction
    assign rounded = product + PROD_W'(128);
    assign shifted = rounded[PROD_W-1:8];

    always_comb begin
        if (shifted > SAT_MAX) begin
            clamped = SAT_MAX[SAMPLE_W-1:0];
        end else if (shifted < SAT_MIN) begin
            clamped = SAT_MIN[SAMPLE_W-1:0];
        end else begin
            clamped = shifted[SAMPLE_W-1:0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= in_valid_i;
        end
    end

    // framing is added further down the chain
    always_ff @(posedge clk_i) begin
        out_beat_o.sample <= clamped;
        out_beat_o.last   <= 1'b0;
    end

endmodule

//--- logic/stream_fifo.sv
`timescale 1ns/1ps

module stream_fifo
    import stream_pkg::*;
#(
    // must be a power of two
    parameter int FIFO_LEN = 8
) (
    input  logic         clk_i,
    input  logic         reset_ni,
    input  logic         wr_valid_i,
    input  sample_beat_t wr_beat_i,
    input  logic         pop_req_i,
    output logic         head_valid_o,
    output sample_beat_t head_beat_o,
    output fifo_status_t status_o
);

    localparam int PTR_W = $clog2(FIFO_LEN);

    sample_beat_t     mem [FIFO_LEN];

    // one extra msb on each pointer tells a full buffer from an empty one
    logic [PTR_W:0]   wr_ptr_q;
    logic [PTR_W:0]   rd_ptr_q;
    logic [PTR_W-1:0] wr_addr;
    logic [PTR_W-1:0] rd_addr;
    logic [PTR_W:0]   fill;
    logic             empty_now;
    logic             full_now;
    logic             wr_en;
    logic             pop_grant;

    assign wr_addr = wr_ptr_q[PTR_W-1:0];
    assign rd_addr = rd_ptr_q[PTR_W-1:0];
    assign fill    = wr_ptr_q - rd_ptr_q;

    assign empty_now = (wr_ptr_q == rd_ptr_q);
    assign full_now  = (wr_addr == rd_addr) && (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W]);

    // the source cannot stall, so a sample that finds the buffer full is lost
    assign wr_en     = wr_valid_i && !full_now;
    assign pop_grant = pop_req_i && !empty_now;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_ptr_q <= '0;
        end else if (wr_en) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_beat_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            rd_ptr_q     <= '0;
            head_valid_o <= 1'b0;
        end else begin
            head_valid_o <= pop_grant;
            if (pop_grant) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    // the head follows the read address every cycle so the next sample can be seen before a pop
    always_ff @(posedge clk_i) begin
        head_beat_o <= mem[rd_addr];
    end

    // flags lag the pointers by one cycle
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            status_o.level    <= '0;
            status_o.full     <= 1'b0;
            status_o.empty    <= 1'b1;
            status_o.overflow <= 1'b0;
        end else begin
            status_o.level    <= 16'(fill);
            status_o.full     <= full_now;
            status_o.empty    <= empty_now;
            status_o.overflow <= wr_valid_i && full_now;
        end
    end

    // every head beat must come from a request that moved the read pointer one step
    assert property (@(posedge clk_i) disable iff (!reset_ni)
        head_valid_o |-> $past(pop_req_i) && (rd_ptr_q == $past(rd_ptr_q) + 1'b1))
        else $error("stream_fifo: head_valid without a granted pop");

    assert property (@(posedge clk_i) disable iff (!reset_ni)
        status_o.level <= 16'(FIFO_LEN))
        else $error("stream_fifo: level above FIFO_LEN");

endmodule

//--- logic/frame_builder.sv
`timescale 1ns/1ps

module frame_builder
    import stream_pkg::*;
(
    input  logic         clk_i,
    input  logic         reset_ni,
    input  frame_len_t   frame_len_i,
    output logic         pop_req_o,
    input  logic         head_valid_i,
    input  sample_beat_t head_beat_i,
    output logic         out_valid_o,
    output sample_beat_t out_beat_o,
    input  logic         out_ready_i
);

    sample_beat_t skid_q [2];
    logic         wr_sel_q;
    logic         rd_sel_q;
    logic [1:0]   count_q;
    logic         inflight_q;
    logic [1:0]   credit;
    logic         out_fire;
    frame_len_t   len_q;
    frame_len_t   pos_q;
    frame_len_t   cur_len;
    logic         is_last;

    assign out_valid_o = (count_q != 2'd0);
    assign out_beat_o  = skid_q[rd_sel_q];
    assign out_fire    = out_valid_o && out_ready_i;

    // entries held plus last cycle's request, less the beat leaving now
    assign credit    = count_q + 2'(inflight_q) - 2'(out_fire);
    assign pop_req_o = (credit < 2'd2);

    // the length is sampled on the first beat of each frame
    assign cur_len = (pos_q != '0) ? len_q :
                     (frame_len_i == '0) ? 16'd1 : frame_len_i;
    assign is_last = (pos_q == cur_len - 16'd1);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_sel_q   <= 1'b0;
            rd_sel_q   <= 1'b0;
            count_q    <= '0;
            inflight_q <= 1'b0;
            len_q      <= 16'd1;
            pos_q      <= '0;
        end else begin
            inflight_q <= pop_req_o;
            count_q    <= count_q + 2'(head_valid_i) - 2'(out_fire);
            if (out_fire) begin
                rd_sel_q <= ~rd_sel_q;
            end
            if (head_valid_i) begin
                wr_sel_q <= ~wr_sel_q;
                len_q    <= cur_len;
                pos_q    <= is_last ? '0 : pos_q + 16'd1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (head_valid_i) begin
            skid_q[wr_sel_q].sample <= head_beat_i.sample;
            skid_q[wr_sel_q].last   <= is_last;
        end
    end

    assert property (@(posedge clk_i) disable iff (!reset_ni)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_beat_o))
        else $error("frame_builder: output beat changed under back-pressure");

endmodule

//--- logic/csr_axil.sv
`timescale 1ns/1ps

module csr_axil
    import stream_pkg::*;
(
    input  logic         clk_i,
    input  logic         reset_ni,
    input  axil_req_t    axil_req_i,
    output axil_rsp_t    axil_rsp_o,
    input  fifo_status_t status_i,
    output gain_t        gain_o,
    output frame_len_t   frame_len_o
);

    localparam gain_t      GAIN_RESET      = 16'd256;
    localparam frame_len_t FRAME_LEN_RESET = 16'd4;

    logic                   bvalid_q;
    logic                   rvalid_q;
    logic [AXIL_DATA_W-1:0] rdata_q;
    logic                   overflow_q;
    logic                   wr_fire;
    logic                   rd_fire;
    logic                   ovf_clear;
    csr_addr_e              wr_addr;
    csr_addr_e              rd_addr;
    logic [AXIL_DATA_W-1:0] status_word;
    logic [AXIL_DATA_W-1:0] rd_word;

    // address and data are taken together once the previous response has gone
    assign wr_fire = axil_req_i.awvalid && axil_req_i.wvalid && !bvalid_q;
    assign rd_fire = axil_req_i.arvalid && !rvalid_q;

    assign wr_addr = csr_addr_e'(axil_req_i.awaddr);
    assign rd_addr = csr_addr_e'(axil_req_i.araddr);

    assign ovf_clear = wr_fire && (wr_addr == REG_STATUS) &&
                       axil_req_i.wstrb[0] && axil_req_i.wdata[0];

    assign status_word = {13'd0, overflow_q, status_i.empty, status_i.full, status_i.level};

    always_comb begin
        case (rd_addr)
            REG_GAIN:      rd_word = {16'd0, gain_o};
            REG_FRAME_LEN: rd_word = {16'd0, frame_len_o};
            REG_STATUS:    rd_word = status_word;
            default:       rd_word = '0;
        endcase
    end

    always_comb begin
        axil_rsp_o.awready = wr_fire;
        axil_rsp_o.wready  = wr_fire;
        axil_rsp_o.bresp   = AXIL_RESP_OKAY;
        axil_rsp_o.bvalid  = bvalid_q;
        axil_rsp_o.arready = !rvalid_q;
        axil_rsp_o.rdata   = rdata_q;
        axil_rsp_o.rresp   = AXIL_RESP_OKAY;
        axil_rsp_o.rvalid  = rvalid_q;
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            gain_o      <= GAIN_RESET;
            frame_len_o <= FRAME_LEN_RESET;
        end else if (wr_fire) begin
            case (wr_addr)
                REG_GAIN: begin
                    if (axil_req_i.wstrb[0]) gain_o[7:0]  <= axil_req_i.wdata[7:0];
                    if (axil_req_i.wstrb[1]) gain_o[15:8] <= axil_req_i.wdata[15:8];
                end
                REG_FRAME_LEN: begin
                    if (axil_req_i.wstrb[0]) frame_len_o[7:0]  <= axil_req_i.wdata[7:0];
                    if (axil_req_i.wstrb[1]) frame_len_o[15:8] <= axil_req_i.wdata[15:8];
                end
                default: begin
                end
            endcase
        end
    end

    // a new overflow in the same cycle as the clear keeps the bit set
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            overflow_q <= 1'b0;
        end else if (status_i.overflow) begin
            overflow_q <= 1'b1;
        end else if (ovf_clear) begin
            overflow_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            if (wr_fire) begin
                bvalid_q <= 1'b1;
            end else if (axil_req_i.bready) begin
                bvalid_q <= 1'b0;
            end
            if (rd_fire) begin
                rvalid_q <= 1'b1;
            end else if (axil_req_i.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_fire) begin
            rdata_q <= rd_word;
        end
    end

    assert property (@(posedge clk_i) disable iff (!reset_ni)
        bvalid_q && !axil_req_i.bready |=> bvalid_q)
        else $error("csr_axil: bvalid dropped before bready");

endmodule

//--- logic/stream_frontend_top.sv
`timescale 1ns/1ps

module stream_frontend_top
    import stream_pkg::*;
#(
    parameter int FIFO_LEN = 8
) (
    input  logic         clk_i,
    input  logic         reset_ni,
    input  logic         in_valid_i,
    input  sample_t      in_sample_i,
    output logic         out_valid_o,
    output sample_beat_t out_beat_o,
    input  logic         out_ready_i,
    input  axil_req_t    axil_req_i,
    output axil_rsp_t    axil_rsp_o
);

    logic         scaled_valid;
    sample_beat_t scaled_beat;
    logic         pop_req;
    logic         head_valid;
    sample_beat_t head_beat;
    fifo_status_t fifo_status;
    gain_t        gain;
    frame_len_t   frame_len;

    sample_scaler sample_scaler_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .in_valid_i  (in_valid_i),
        .in_sample_i (in_sample_i),
        .gain_i      (gain),
        .out_valid_o (scaled_valid),
        .out_beat_o  (scaled_beat)
    );

    stream_fifo #(
        .FIFO_LEN (FIFO_LEN)
    ) stream_fifo_i (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .wr_valid_i   (scaled_valid),
        .wr_beat_i    (scaled_beat),
        .pop_req_i    (pop_req),
        .head_valid_o (head_valid),
        .head_beat_o  (head_beat),
        .status_o     (fifo_status)
    );

    frame_builder frame_builder_i (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .frame_len_i  (frame_len),
        .pop_req_o    (pop_req),
        .head_valid_i (head_valid),
        .head_beat_i  (head_beat),
        .out_valid_o  (out_valid_o),
        .out_beat_o   (out_beat_o),
        .out_ready_i  (out_ready_i)
    );

    csr_axil csr_axil_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .axil_req_i  (axil_req_i),
        .axil_rsp_o  (axil_rsp_o),
        .status_i    (fifo_status),
        .gain_o      (gain),
        .frame_len_o (frame_len)
    );

endmodule

//--- include/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// included inside a module that imports stream_pkg

// Galois form, taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
        return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
endfunction

// same round, shift and clamp as the scaler
function automatic sample_t ref_scale(input sample_t s, input gain_t g);
    longint prod;
    longint q;
    prod = longint'(s) * longint'(g);
    q = (prod + 128) >>> 8;
    if (q > 32767) begin
        return 16'sh7fff;
    end
    if (q < -32768) begin
        return 16'sh8000;
    end
    return sample_t'(q);
endfunction

// pos counts from 0 at the start of each frame
function automatic logic ref_last(input int unsigned pos, input frame_len_t len);
    int unsigned eff;
    eff = (len == '0) ? 1 : int'(len);
    return pos == eff - 1;
endfunction

task automatic check_beat(input string name, input sample_beat_t got, input sample_beat_t exp);
    if (got !== exp) begin
        $display("FAILED %s: got %h expected %h", name, got, exp);
        $display("Checks failed");
        $fatal(1, "mismatch on %s", name);
    end
endtask

task automatic check_reg(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("FAILED %s: got %h expected %h", name, got, exp);
        $display("Checks failed");
        $fatal(1, "mismatch on %s", name);
    end
endtask

`endif

//--- tests/tb_stream_frontend.sv
`timescale 1ns/1ps

module tb_stream_frontend
    import stream_pkg::*;
();

    `include "tb_checks.svh"

    localparam int FIFO_LEN        = 8;
    localparam int BP_SAMPLES      = 60;
    localparam int N_SAMPLES       = 40 + 25 + BP_SAMPLES + FIFO_LEN + 5;
    localparam int WATCHDOG_CYCLES = 40 * N_SAMPLES + 2000;

    localparam logic [31:0] STATUS_FULL  = 32'h0001_0000;
    localparam logic [31:0] STATUS_EMPTY = 32'h0002_0000;
    localparam logic [31:0] STATUS_OVF   = 32'h0004_0000;

    // the extremes plus a few ordinary values, run against every gain
    localparam sample_t SCALE_SET [8] = '{16'sh7fff, 16'sh8000, 16'sd1000, -16'sd1000,
                                          16'sh1234, -16'sd3, 16'sd0, 16'sd127};
    // 0x0300 and 0xffff push the large samples into saturation
    localparam gain_t GAIN_SET [5] = '{16'd256, 16'h0080, 16'h0300, 16'hffff, 16'd0};

    localparam frame_len_t FRAME_LENS   [3] = '{16'd1, 16'd3, 16'd5};
    localparam int         FRAME_COUNTS [3] = '{6, 9, 10};

    logic         clk_i;
    logic         reset_ni;
    logic         in_valid_i;
    sample_t      in_sample_i;
    logic         out_valid_o;
    sample_beat_t out_beat_o;
    logic         out_ready_i;
    axil_req_t    axil_req_i;
    axil_rsp_t    axil_rsp_o;

    logic [31:0]  lfsr_state;
    gain_t        gain_model;
    frame_len_t   len_model;
    sample_t      exp_q [$];
    int unsigned  frame_pos;
    frame_len_t   frame_len_cur;
    logic         stall_q;
    sample_beat_t held_beat;

    stream_frontend_top #(
        .FIFO_LEN (FIFO_LEN)
    ) stream_frontend_top_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .in_valid_i  (in_valid_i),
        .in_sample_i (in_sample_i),
        .out_valid_o (out_valid_o),
        .out_beat_o  (out_beat_o),
        .out_ready_i (out_ready_i),
        .axil_req_i  (axil_req_i),
        .axil_rsp_o  (axil_rsp_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // newest bit goes in at the bottom
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1, "%s", what);
    endtask

    task automatic drive_sample(input sample_t s, input logic keep);
        @(negedge clk_i);
        in_valid_i  = 1'b1;
        in_sample_i = s;
        if (keep) begin
            exp_q.push_back(ref_scale(s, gain_model));
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk_i);
            in_valid_i = 1'b0;
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(negedge clk_i);
        end
        // extra cycles so that a surplus beat shows up at the monitor
        idle_cycles(8);
    endtask

    task automatic axil_write(input csr_addr_e addr, input logic [31:0] data,
                              input logic [3:0] strb);
        @(negedge clk_i);
        axil_req_i.awaddr  = addr;
        axil_req_i.awvalid = 1'b1;
        axil_req_i.wdata   = data;
        axil_req_i.wstrb   = strb;
        axil_req_i.wvalid  = 1'b1;
        axil_req_i.bready  = 1'b1;
        do begin
            @(posedge clk_i);
        end while (!axil_rsp_o.awready);
        // address and data are taken in the same cycle
        check_reg("wready", {31'd0, axil_rsp_o.wready}, 32'd1);
        @(negedge clk_i);
        axil_req_i.awvalid = 1'b0;
        axil_req_i.wvalid  = 1'b0;
        do begin
            @(posedge clk_i);
        end while (!axil_rsp_o.bvalid);
        check_reg("bresp", {30'd0, axil_rsp_o.bresp}, {30'd0, AXIL_RESP_OKAY});
        @(negedge clk_i);
        axil_req_i.bready = 1'b0;
    endtask

    task automatic axil_read(input csr_addr_e addr, output logic [31:0] data);
        @(negedge clk_i);
        axil_req_i.araddr  = addr;
        axil_req_i.arvalid = 1'b1;
        axil_req_i.rready  = 1'b1;
        do begin
            @(posedge clk_i);
        end while (!axil_rsp_o.arready);
        @(negedge clk_i);
        axil_req_i.arvalid = 1'b0;
        do begin
            @(posedge clk_i);
        end while (!axil_rsp_o.rvalid);
        data = axil_rsp_o.rdata;
        check_reg("rresp", {30'd0, axil_rsp_o.rresp}, {30'd0, AXIL_RESP_OKAY});
        @(negedge clk_i);
        axil_req_i.rready = 1'b0;
    endtask

    task automatic read_expect(input csr_addr_e addr, input string name,
                               input logic [31:0] exp);
        logic [31:0] got;
        axil_read(addr, got);
        check_reg(name, got, exp);
    endtask

    task automatic set_gain(input gain_t g);
        axil_write(REG_GAIN, {16'd0, g}, 4'b0011);
        gain_model = g;
    endtask

    task automatic set_frame_len(input frame_len_t len);
        axil_write(REG_FRAME_LEN, {16'd0, len}, 4'b0011);
        len_model = len;
    endtask

    // every transfer is checked in order, and a stalled beat must not move
    always @(posedge clk_i) begin
        sample_beat_t exp_beat;
        if (!reset_ni) begin
            stall_q = 1'b0;
        end else if (stall_q && !out_valid_o) begin
            fail_now("out_valid_o dropped while the sink was stalling");
        end else if (out_valid_o && exp_q.size() == 0) begin
            fail_now("out_valid_o high with no sample left to expect");
        end else begin
            if (stall_q) begin
                check_beat("out_beat_o held", out_beat_o, held_beat);
            end
            if (out_valid_o && out_ready_i) begin
                // a new length only counts from a frame boundary
                if (frame_pos == 0) begin
                    frame_len_cur = len_model;
                end
                exp_beat.sample = exp_q.pop_front();
                exp_beat.last   = ref_last(frame_pos, frame_len_cur);
                check_beat("out_beat_o", out_beat_o, exp_beat);
                frame_pos = exp_beat.last ? 0 : frame_pos + 1;
            end
            stall_q   = out_valid_o && !out_ready_i;
            held_beat = out_beat_o;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        fail_now($sformatf("timeout, the run did not finish within %0d cycles",
                           WATCHDOG_CYCLES));
    end

    initial begin
        logic [31:0] rnd;
        logic [31:0] ready_bits;
        logic [31:0] gap_bit;
        int          sent;
        in_valid_i    = 1'b0;
        in_sample_i   = '0;
        out_ready_i   = 1'b0;
        axil_req_i    = '0;
        reset_ni      = 1'b0;
        lfsr_state    = 32'h08d1217b;
        gain_model    = 16'd256;
        len_model     = 16'd4;
        frame_pos     = 0;
        frame_len_cur = 16'd4;
        stall_q       = 1'b0;
        held_beat     = '0;
        repeat (2) @(negedge clk_i);
        reset_ni = 1'b1;

        read_expect(REG_GAIN, "gain", 32'd256);
        read_expect(REG_FRAME_LEN, "frame_len", 32'd4);
        read_expect(REG_STATUS, "status", STATUS_EMPTY);

        axil_write(REG_GAIN, 32'h0000_0123, 4'b0011);
        read_expect(REG_GAIN, "gain", 32'h0000_0123);
        axil_write(REG_GAIN, 32'h0000_ab99, 4'b0010);
        read_expect(REG_GAIN, "gain", 32'h0000_ab23);
        axil_write(REG_FRAME_LEN, 32'h0000_0007, 4'b1111);
        read_expect(REG_FRAME_LEN, "frame_len", 32'h0000_0007);
        axil_write(REG_FRAME_LEN, 32'h0000_3355, 4'b0001);
        read_expect(REG_FRAME_LEN, "frame_len", 32'h0000_0055);
        set_frame_len(16'd4);

        out_ready_i = 1'b1;
        foreach (GAIN_SET[g]) begin
            set_gain(GAIN_SET[g]);
            foreach (SCALE_SET[s]) begin
                drive_sample(SCALE_SET[s], 1'b1);
            end
            idle_cycles(1);
            wait_drain();
        end

        set_gain(16'd256);
        foreach (FRAME_LENS[k]) begin
            set_frame_len(FRAME_LENS[k]);
            for (int i = 0; i < FRAME_COUNTS[k]; i++) begin
                rnd = take_bits(16);
                drive_sample(rnd[15:0], 1'b1);
            end
            idle_cycles(1);
            wait_drain();
        end

        // input is held back while the system is near full, so nothing may drop here
        set_gain(16'h0180);
        set_frame_len(16'd3);
        sent = 0;
        while (sent < BP_SAMPLES || exp_q.size() != 0) begin
            @(negedge clk_i);
            ready_bits  = take_bits(2);
            gap_bit     = take_bits(1);
            out_ready_i = (ready_bits[1:0] != 2'b00);
            if (sent < BP_SAMPLES && exp_q.size() < FIFO_LEN && gap_bit[0]) begin
                rnd         = take_bits(16);
                in_valid_i  = 1'b1;
                in_sample_i = rnd[15:0];
                exp_q.push_back(ref_scale(rnd[15:0], gain_model));
                sent++;
            end else begin
                in_valid_i = 1'b0;
            end
        end
        out_ready_i = 1'b1;
        idle_cycles(8);

        // FIFO_LEN in the FIFO and two in the frame builder, the rest is lost
        set_gain(16'd256);
        @(negedge clk_i);
        out_ready_i = 1'b0;
        for (int i = 0; i < FIFO_LEN + 5; i++) begin
            rnd = take_bits(16);
            drive_sample(rnd[15:0], i < FIFO_LEN + 2);
        end
        idle_cycles(4);
        read_expect(REG_STATUS, "status", STATUS_FULL | STATUS_OVF | 32'(FIFO_LEN));
        @(negedge clk_i);
        out_ready_i = 1'b1;
        wait_drain();
        axil_write(REG_STATUS, 32'h0000_0001, 4'b0001);
        read_expect(REG_STATUS, "status", STATUS_EMPTY);

        $display("All checks passed");
        $finish;
    end

endmodule

//--- src.f
+incdir+include
logic/stream_pkg.sv
logic/sample_scaler.sv
logic/stream_fifo.sv
logic/frame_builder.sv
logic/csr_axil.sv
logic/stream_frontend_top.sv
tests/tb_stream_frontend.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 -Mdir obj_dir \
    --top-module tb_stream_frontend -f src.f \
    && ./obj_dir/Vtb_stream_frontend 2>&1 | tee sim.log

grep -q "Checks failed" sim.log && { echo "simulation failed"; exit 1; }
grep -q "All checks passed" sim.log || { echo "no pass line in sim.log"; exit 1; }
echo "simulation passed"
